// ==== include/semcoDemod_consts.svh ====
`ifndef SEMCODEMOD_CONSTS_SVH
`define SEMCODEMOD_CONSTS_SVH

//**************************************************************************
// Datapath widths
//**************************************************************************

// Offset binary word from the ADC
`define ADC_WIDTH       14
// Signed sample shared with the demodulator
`define SAMPLE_WIDTH    18
// Offset binary word to each DAC
`define DAC_WIDTH       14

//**************************************************************************
// Wishbone register space
//**************************************************************************

`define WB_ADDR_WIDTH   8
`define WB_DATA_WIDTH   32

// Byte offsets, word aligned
`define REG_VERSION     8'h00
`define REG_CONTROL     8'h04
`define REG_STATUS      8'h08

`define VERSION_NUMBER  16'd454

// Values after reset
`define CONTROL_RESET   16'h0000
`define DAC_MIDSCALE    14'h2000

`endif

// ==== verilog/semcoPkg.sv ====
`default_nettype none

`include "semcoDemod_consts.svh"

package semcoPkg;

    // Symbol source for a clock and data output channel
    typedef enum logic [3:0] {
        srcLegacyI     = 4'd0,
        srcLegacyQ     = 4'd1,
        srcPcmTrellis  = 4'd2,
        srcDualDecoder = 4'd4,
        srcCh1Decoder  = 4'd5
    } symbolSource_e;

    // Sample source for a DAC
    typedef enum logic [3:0] {
        dacSrcDemod     = 4'd0,
        dacSrcFmTrellis = 4'd1
    } dacSource_e;

    // Wishbone classic request, master to slave
    typedef struct packed {
        logic                          cyc;
        logic                          stb;
        logic                          we;
        logic [3:0]                    sel;
        logic [`WB_ADDR_WIDTH-1:0]     adr;
        logic [`WB_DATA_WIDTH-1:0]     dat;
    } wbReq_t;

    // Wishbone classic response
    typedef struct packed {
        logic                          ack;
        logic [`WB_DATA_WIDTH-1:0]     dat;
    } wbRsp_t;

    // One strobe and one bit for every symbol source
    typedef struct packed {
        logic iSymEn;
        logic iBit;
        logic qSymEn;
        logic qBit;
        logic trellisSymEn;
        logic trellisBit;
        logic dualSymEn;
        logic dualBitI;
        logic ch1DecSymEn;
        logic ch1DecBit;
    } symbolStreams_t;

    typedef struct packed {
        logic signed [`SAMPLE_WIDTH-1:0] data;
        logic                            clkEn;
    } dacSample_t;

    // Same layout as the CONTROL register, ch0Source in bits 3:0
    typedef struct packed {
        dacSource_e    dac1Source;
        dacSource_e    dac0Source;
        symbolSource_e ch1Source;
        symbolSource_e ch0Source;
    } topControl_t;

endpackage

`default_nettype wire

// ==== verilog/wbRegisterBank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "semcoDemod_consts.svh"

module wbRegisterBank import semcoPkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire wbReq_t wbReq,
    output wbRsp_t      wbRsp,
    input  wire logic   timingLock,
    input  wire logic   carrierLock,
    output topControl_t control
);

    logic                          ack;
    logic                          request;
    logic                          writeStrobe;
    logic [`WB_ADDR_WIDTH-1:0]     wordOffset;
    logic [`WB_DATA_WIDTH-1:0]     readMux;
    logic [`WB_DATA_WIDTH-1:0]     rdData;
    logic [$bits(topControl_t)-1:0] controlReg;

    //**************************************************************************
    // Handshake
    //**************************************************************************

    // A request already being acknowledged is not seen again,
    // so back-to-back cycles still get one-cycle acks
    assign request     = wbReq.cyc & wbReq.stb & ~ack;
    assign writeStrobe = request & wbReq.we;

    // Byte lanes within the word are selected by sel
    assign wordOffset = {wbReq.adr[`WB_ADDR_WIDTH-1:2], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end
        else begin
            ack <= request;
        end
    end

    //**************************************************************************
    // Read path
    //**************************************************************************
    always_comb begin
        case (wordOffset)
            `REG_VERSION: begin
                readMux = `WB_DATA_WIDTH'(`VERSION_NUMBER);
            end
            `REG_CONTROL: begin
                readMux = `WB_DATA_WIDTH'(controlReg);
            end
            `REG_STATUS: begin
                readMux = `WB_DATA_WIDTH'({carrierLock, timingLock});
            end
            // Unmapped reads return zero
            default: begin
                readMux = '0;
            end
        endcase
    end

    // Captured with the request, held through the ack cycle
    always_ff @(posedge clk) begin
        if (request) begin
            rdData <= readMux;
        end
    end

    //**************************************************************************
    // Control register
    //**************************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            controlReg <= `CONTROL_RESET;
        end
        else if (writeStrobe && (wordOffset == `REG_CONTROL)) begin
            if (wbReq.sel[0]) begin
                controlReg[7:0] <= wbReq.dat[7:0];
            end
            if (wbReq.sel[1]) begin
                controlReg[15:8] <= wbReq.dat[15:8];
            end
        end
    end

    // Field layout matches topControl_t
    assign control = topControl_t'(controlReg);

    assign wbRsp.ack = ack;
    assign wbRsp.dat = rdData;

endmodule

`default_nettype wire

// ==== verilog/dataConverterPort.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "semcoDemod_consts.svh"

module dataConverterPort import semcoPkg::*; (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic        [`ADC_WIDTH-1:0]     adc0,
    output logic signed      [`SAMPLE_WIDTH-1:0]  adcSample,
    input  wire dacSource_e                       dac0Source,
    input  wire dacSource_e                       dac1Source,
    input  wire dacSample_t                       demodDac0,
    input  wire dacSample_t                       demodDac1,
    input  wire dacSample_t                       trellisDac0,
    input  wire dacSample_t                       trellisDac1,
    output logic             [`DAC_WIDTH-1:0]     dac0Data,
    output logic             [`DAC_WIDTH-1:0]     dac1Data
);

    // Anything other than the trellis select falls back to demod
    function automatic logic signed [`SAMPLE_WIDTH-1:0] pickSample(
        input dacSource_e src,
        input dacSample_t demod,
        input dacSample_t trellis
    );
        case (src)
            dacSrcFmTrellis: return trellis.data;
            default:         return demod.data;
        endcase
    endfunction

    // Two's complement to offset binary, top DAC_WIDTH bits
    function automatic logic [`DAC_WIDTH-1:0] toOffsetBinary(
        input logic signed [`SAMPLE_WIDTH-1:0] sample
    );
        return {~sample[`SAMPLE_WIDTH-1], sample[`SAMPLE_WIDTH-2 -: `DAC_WIDTH-1]};
    endfunction

    logic             [`ADC_WIDTH-1:0]    adcReg;
    logic signed      [`SAMPLE_WIDTH-1:0] dac0Sample;
    logic signed      [`SAMPLE_WIDTH-1:0] dac1Sample;

    //**************************************************************************
    // ADC reclock
    //**************************************************************************
    always_ff @(posedge clk) begin
        adcReg <= adc0;
    end

    // Flip the MSB for two's complement, then scale up by 16
    always_ff @(posedge clk) begin
        if (reset) begin
            adcSample <= '0;
        end
        else begin
            adcSample <= {~adcReg[`ADC_WIDTH-1], adcReg[`ADC_WIDTH-2:0],
                          {(`SAMPLE_WIDTH-`ADC_WIDTH){1'b0}}};
        end
    end

    //**************************************************************************
    // DAC source select and formatting
    //**************************************************************************
    always_ff @(posedge clk) begin
        dac0Sample <= pickSample(dac0Source, demodDac0, trellisDac0);
        dac1Sample <= pickSample(dac1Source, demodDac1, trellisDac1);
    end

    // Outputs park at midscale during reset
    always_ff @(posedge clk) begin
        if (reset) begin
            dac0Data <= `DAC_MIDSCALE;
            dac1Data <= `DAC_MIDSCALE;
        end
        else begin
            dac0Data <= toOffsetBinary(dac0Sample);
            dac1Data <= toOffsetBinary(dac1Sample);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/clockDataChannel.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockDataChannel import semcoPkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire symbolSource_e  source,
    input  wire symbolStreams_t symbols,
    output logic                chClk,
    output logic                chData
);

    logic selSymEn;
    logic selBit;

    //**************************************************************************
    // Source select
    //**************************************************************************
    always_comb begin
        case (source)
            srcLegacyQ: begin
                selSymEn = symbols.qSymEn;
                selBit   = symbols.qBit;
            end
            srcPcmTrellis: begin
                selSymEn = symbols.trellisSymEn;
                selBit   = symbols.trellisBit;
            end
            srcDualDecoder: begin
                selSymEn = symbols.dualSymEn;
                selBit   = symbols.dualBitI;
            end
            srcCh1Decoder: begin
                selSymEn = symbols.ch1DecSymEn;
                selBit   = symbols.ch1DecBit;
            end
            // srcLegacyI and any unused code
            default: begin
                selSymEn = symbols.iSymEn;
                selBit   = symbols.iBit;
            end
        endcase
    end

    //**************************************************************************
    // Output clock pulse and data bit
    //**************************************************************************

    // One-cycle clock pulse per symbol
    always_ff @(posedge clk) begin
        if (reset) begin
            chClk <= 1'b0;
        end
        else begin
            chClk <= selSymEn;
        end
    end

    // Data changes together with the clock pulse and holds between symbols
    always_ff @(posedge clk) begin
        if (reset) begin
            chData <= 1'b0;
        end
        else if (selSymEn) begin
            chData <= selBit;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/semcoDemodTop.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "semcoDemod_consts.svh"

module semcoDemodTop import semcoPkg::*; (
    input  wire logic                             clk,
    input  wire logic                             reset,

    // Wishbone slave port
    input  wire wbReq_t                           wbReq,
    output wbRsp_t                                wbRsp,

    // ADC in, reclocked sample out to the demodulator
    input  wire logic        [`ADC_WIDTH-1:0]     adc0,
    output logic signed      [`SAMPLE_WIDTH-1:0]  adcSample,

    // Results from the DSP blocks
    input  wire symbolStreams_t                   symbols,
    input  wire dacSample_t                       demodDac0,
    input  wire dacSample_t                       demodDac1,
    input  wire dacSample_t                       trellisDac0,
    input  wire dacSample_t                       trellisDac1,
    input  wire logic                             timingLock,
    input  wire logic                             carrierLock,

    // DAC data
    output logic             [`DAC_WIDTH-1:0]     dac0Data,
    output logic             [`DAC_WIDTH-1:0]     dac1Data,

    // Clock and data outputs
    output logic                                  ch0Clk,
    output logic                                  ch0Data,
    output logic                                  ch1Clk,
    output logic                                  ch1Data,

    // Lock LEDs, active low
    output logic                                  lockLed0n,
    output logic                                  lockLed1n
);

    topControl_t control;

    //**************************************************************************
    // Register bank
    //**************************************************************************
    wbRegisterBank regBank (
        .clk        (clk),
        .reset      (reset),
        .wbReq      (wbReq),
        .wbRsp      (wbRsp),
        .timingLock (timingLock),
        .carrierLock(carrierLock),
        .control    (control)
    );

    //**************************************************************************
    // ADC and DAC formatting
    //**************************************************************************
    dataConverterPort converterPort (
        .clk        (clk),
        .reset      (reset),
        .adc0       (adc0),
        .adcSample  (adcSample),
        .dac0Source (control.dac0Source),
        .dac1Source (control.dac1Source),
        .demodDac0  (demodDac0),
        .demodDac1  (demodDac1),
        .trellisDac0(trellisDac0),
        .trellisDac1(trellisDac1),
        .dac0Data   (dac0Data),
        .dac1Data   (dac1Data)
    );

    //**************************************************************************
    // Clock and data channels
    //**************************************************************************
    clockDataChannel ch0Output (
        .clk    (clk),
        .reset  (reset),
        .source (control.ch0Source),
        .symbols(symbols),
        .chClk  (ch0Clk),
        .chData (ch0Data)
    );

    clockDataChannel ch1Output (
        .clk    (clk),
        .reset  (reset),
        .source (control.ch1Source),
        .symbols(symbols),
        .chClk  (ch1Clk),
        .chData (ch1Data)
    );

    // LEDs light when locked
    assign lockLed0n = ~timingLock;
    assign lockLed1n = ~carrierLock;

endmodule

`default_nettype wire

// ==== testbench/semcoDemodProps.sv ====
`timescale 1ns/10ps
`default_nettype none

module semcoDemodProps import semcoPkg::*; (
    input wire logic   clk,
    input wire logic   reset,
    input wire wbReq_t wbReq,
    input wire wbRsp_t wbRsp
);

    int assertFailures = 0;

    // Single-cycle ack, also for back-to-back requests
    ackSingleCycle: assert property (@(posedge clk) disable iff (reset)
        wbRsp.ack |=> !wbRsp.ack)
    else begin
        $error("ack stayed high for more than one cycle");
        assertFailures++;
    end

    // Every ack answers a request seen on the edge before
    ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
        $rose(wbRsp.ack) |-> $past(wbReq.cyc && wbReq.stb))
    else begin
        $error("ack rose without cyc and stb");
        assertFailures++;
    end

    ackLowInReset: assert property (@(posedge clk) reset |=> !wbRsp.ack)
    else begin
        $error("ack high after a reset cycle");
        assertFailures++;
    end

endmodule

bind wbRegisterBank semcoDemodProps props (
    .clk  (clk),
    .reset(reset),
    .wbReq(wbReq),
    .wbRsp(wbRsp)
);

`default_nettype wire

// ==== testbench/tbSemcoDemodTop.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "semcoDemod_consts.svh"

module tbSemcoDemodTop import semcoPkg::*; ();

    localparam int HALF_PERIOD = 10;
    localparam int DRIVE_DELAY = 2;
    localparam int ACK_TIMEOUT = 20;

    logic                            clk = 1'b0;
    logic                            reset;
    wbReq_t                          wbReq;
    wbRsp_t                          wbRsp;
    logic        [`ADC_WIDTH-1:0]    adc0;
    logic signed [`SAMPLE_WIDTH-1:0] adcSample;
    symbolStreams_t                  symbols;
    dacSample_t                      demodDac0, demodDac1, trellisDac0, trellisDac1;
    logic                            timingLock, carrierLock;
    logic        [`DAC_WIDTH-1:0]    dac0Data, dac1Data;
    logic                            ch0Clk, ch0Data, ch1Clk, ch1Data;
    logic                            lockLed0n, lockLed1n;

    int          errorCount;
    int          checkCount;
    logic        freezeLocks;
    logic [15:0] shadowControl;

    // Model delay lines where D2 holds inputs from two cycles back
    logic [`ADC_WIDTH-1:0]    adcD1, adcD2;
    logic [`SAMPLE_WIDTH-1:0] dac0D1, dac0D2, dac1D1, dac1D2;
    logic [1:0]               pendCh0, pendCh1;
    logic                     expData0, expData1;
    logic                     resetPrev;

    semcoDemodTop dut (.*);

    initial begin
        forever #HALF_PERIOD clk = ~clk;
    end

    //**************************************************************************
    // Conversion rules
    //**************************************************************************

    // Remove the midscale offset and scale by 16
    function automatic logic [`SAMPLE_WIDTH-1:0] adcToSample(input logic [`ADC_WIDTH-1:0] word);
        int value;
        value = (int'(word) - 8192) * 16;
        return value[`SAMPLE_WIDTH-1:0];
    endfunction

    function automatic logic [`DAC_WIDTH-1:0] sampleToDac(input logic [`SAMPLE_WIDTH-1:0] sample);
        int value;
        value = (int'($signed(sample)) >>> 4) + 8192;
        return value[`DAC_WIDTH-1:0];
    endfunction

    function automatic logic [`SAMPLE_WIDTH-1:0] dacChoice(input logic [3:0] code,
                                                           input dacSample_t demod,
                                                           input dacSample_t trellis);
        if (code == 4'd1) begin
            return trellis.data;
        end
        else begin
            return demod.data;
        end
    endfunction

    // Strobe and bit of the stream a channel code names
    function automatic logic [1:0] streamChoice(input logic [3:0] code, input symbolStreams_t s);
        case (code)
            srcLegacyQ:     return {s.qSymEn, s.qBit};
            srcPcmTrellis:  return {s.trellisSymEn, s.trellisBit};
            srcDualDecoder: return {s.dualSymEn, s.dualBitI};
            srcCh1Decoder:  return {s.ch1DecSymEn, s.ch1DecBit};
            default:        return {s.iSymEn, s.iBit};
        endcase
    endfunction

    //**************************************************************************
    // Checks and run control
    //**************************************************************************
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic finishRun();
        int assertCount;
        assertCount = dut.regBank.props.assertFailures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, assertCount);
        if (errorCount == 0 && assertCount == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        errorCount++;
        finishRun();
    endtask

    task automatic randomizeInputs();
        logic [31:0] r;
        r = $urandom;
        adc0 = r[`ADC_WIDTH-1:0];
        r = $urandom;
        symbols = r[9:0];
        r = $urandom;
        demodDac0 = r[18:0];
        r = $urandom;
        demodDac1 = r[18:0];
        r = $urandom;
        trellisDac0 = r[18:0];
        r = $urandom;
        trellisDac1 = r[18:0];
        if (!freezeLocks) begin
            r = $urandom;
            timingLock = r[0];
            carrierLock = r[1];
        end
    endtask

    task automatic driveRandomInputs();
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            randomizeInputs();
        end
    endtask

    //**************************************************************************
    // Wishbone master
    //**************************************************************************
    task automatic waitForAck(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end while (!wbRsp.ack && cycles < ACK_TIMEOUT);
        if (!wbRsp.ack) begin
            abortRun($sformatf("Timeout: no Wishbone ack for the %s", what));
        end
    endtask

    task automatic wbWrite(input logic [7:0] addr, input logic [31:0] data, input logic [3:0] sel);
        @(posedge clk);
        #DRIVE_DELAY;
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: sel, adr: addr, dat: data};
        waitForAck($sformatf("write to 0x%0h", addr));
        // Shadow copy changes on the same edge as the register
        if ({addr[7:2], 2'b00} == `REG_CONTROL) begin
            if (sel[0]) begin
                shadowControl[7:0] = data[7:0];
            end
            if (sel[1]) begin
                shadowControl[15:8] = data[15:8];
            end
        end
        wbReq = '0;
    endtask

    task automatic wbRead(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: 4'hF, adr: addr, dat: '0};
        waitForAck($sformatf("read of 0x%0h", addr));
        data = wbRsp.dat;
        wbReq = '0;
    endtask

    //**************************************************************************
    // Model compared on the falling edge
    //**************************************************************************
    always @(negedge clk) begin
        logic [`SAMPLE_WIDTH-1:0] expAdc;
        logic [`DAC_WIDTH-1:0]    expDac0, expDac1;
        if (resetPrev) begin
            expAdc = '0;
            expDac0 = 14'h2000;
            expDac1 = 14'h2000;
            pendCh0 = 2'b00;
            pendCh1 = 2'b00;
            expData0 = 1'b0;
            expData1 = 1'b0;
        end
        else begin
            expAdc = adcToSample(adcD2);
            expDac0 = sampleToDac(dac0D2);
            expDac1 = sampleToDac(dac1D2);
            if (pendCh0[1]) begin
                expData0 = pendCh0[0];
            end
            if (pendCh1[1]) begin
                expData1 = pendCh1[0];
            end
        end
        checkValue("adcSample", $unsigned(adcSample), expAdc);
        checkValue("dac0Data", dac0Data, expDac0);
        checkValue("dac1Data", dac1Data, expDac1);
        checkValue("ch0Clk", ch0Clk, pendCh0[1]);
        checkValue("ch1Clk", ch1Clk, pendCh1[1]);
        checkValue("ch0Data", ch0Data, expData0);
        checkValue("ch1Data", ch1Data, expData1);
        checkValue("lockLed0n", lockLed0n, !timingLock);
        checkValue("lockLed1n", lockLed1n, !carrierLock);
        adcD2 = adcD1;
        adcD1 = adc0;
        dac0D2 = dac0D1;
        dac0D1 = dacChoice(shadowControl[11:8], demodDac0, trellisDac0);
        dac1D2 = dac1D1;
        dac1D1 = dacChoice(shadowControl[15:12], demodDac1, trellisDac1);
        pendCh0 = streamChoice(shadowControl[3:0], symbols);
        pendCh1 = streamChoice(shadowControl[7:4], symbols);
        resetPrev = reset;
    end

    //**************************************************************************
    // Test sequence
    //**************************************************************************
    initial begin
        logic [31:0] readData;
        logic [31:0] writeData;
        logic [31:0] rnd;
        logic [3:0]  dac0Code;
        logic [3:0]  chCodes [6];
        void'($urandom(74640));
        errorCount = 0;
        checkCount = 0;
        freezeLocks = 1'b0;
        shadowControl = '0;
        resetPrev = 1'b1;
        reset = 1'b1;
        wbReq = '0;
        randomizeInputs();
        fork
            driveRandomInputs();
        join_none
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        wbRead(`REG_VERSION, readData);
        checkValue("VERSION", readData, 32'd454);

        // All five channel sources plus unused codes 9 and 10
        chCodes = '{srcLegacyI, srcLegacyQ, srcPcmTrellis, srcDualDecoder, srcCh1Decoder, 4'd9};
        for (int i = 0; i < 6; i++) begin
            dac0Code = (i == 5) ? 4'hA : {3'b000, i[0]};
            writeData = {16'h0000, {3'b000, ~i[0]}, dac0Code, chCodes[5-i], chCodes[i]};
            wbWrite(`REG_CONTROL, writeData, 4'hF);
            repeat (40) @(posedge clk);
        end

        // Random data and byte lanes followed by writes that must be ignored
        for (int i = 0; i < 24; i++) begin
            rnd = $urandom;
            wbWrite(`REG_CONTROL, $urandom, rnd[3:0]);
            wbRead(`REG_CONTROL, readData);
            checkValue("CONTROL", readData, {16'h0000, shadowControl});
            repeat (6) @(posedge clk);
        end
        wbWrite(`REG_STATUS, $urandom, 4'hF);
        wbWrite(8'h40, $urandom, 4'hF);
        wbRead(`REG_CONTROL, readData);
        checkValue("CONTROL", readData, {16'h0000, shadowControl});

        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            freezeLocks = 1'b1;
            wbRead(`REG_STATUS, readData);
            checkValue("STATUS", readData, {30'h0, carrierLock, timingLock});
            freezeLocks = 1'b0;
        end

        wbRead(8'h0C, readData);
        checkValue("unmapped 0x0C", readData, 32'h0);
        wbRead(8'hFC, readData);
        checkValue("unmapped 0xFC", readData, 32'h0);

        repeat (10) @(posedge clk);
        finishRun();
    end

endmodule

`default_nettype wire

// ==== Bender.yml ====
package:
  name: semco_demod

export_include_dirs:
  - include

sources:
  - files:
      - verilog/semcoPkg.sv
      - verilog/wbRegisterBank.sv
      - verilog/dataConverterPort.sv
      - verilog/clockDataChannel.sv
      - verilog/semcoDemodTop.sv
  - target: simulation
    files:
      - testbench/semcoDemodProps.sv
      - testbench/tbSemcoDemodTop.sv

// ==== semcoDemodTop.f ====
+incdir+include
verilog/semcoPkg.sv
verilog/wbRegisterBank.sv
verilog/dataConverterPort.sv
verilog/clockDataChannel.sv
verilog/semcoDemodTop.sv
testbench/semcoDemodProps.sv
testbench/tbSemcoDemodTop.sv
